//--- bench/tb_tasks.svh
// Checker, drive helpers, divider model and directed tests, included by the scoreboard bench top

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		$display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
		$display("Simulation failed");
		$fatal(1);
	end
endtask

task automatic fail_now(input string why);
	$display("%s at t=%0t", why, $time);
	$display("Simulation failed");
	$fatal(1);
endtask

// One clock, then settle to the drive point
task automatic step();
	@(posedge sys_clk);
	#1;
endtask

task automatic idle();
	issue = '0;
	exec = '0;
	imm_wr = 1'b0;
endtask

task automatic put_issue(input sboard_pkg::reg_addr_t d, input sboard_pkg::reg_addr_t s,
		input logic drd, input logic srd, input logic dv);
	issue = '{valid: 1'b1, dst: d, src: s, dst_rd: drd, src_rd: srd, is_div: dv};
endtask

task automatic put_exec(input logic alu, input logic mov, input logic imm, input logic dv);
	exec = '{exe: 1'b1, alu_wr: alu, mov_wr: mov, imm_ld: imm, div_start: dv};
endtask

// Enable always checked, address and data only for an expected write
task automatic check_port(input string name, input sboard_pkg::rf_write_t p, input logic en,
		input sboard_pkg::reg_addr_t a, input sboard_pkg::data_t d);
	check({name, ".en"}, 64'(p.en), 64'(en));
	if (en) begin
		check({name, ".addr"}, 64'(p.addr), 64'(a));
		check({name, ".data"}, 64'(p.data), 64'(d));
	end
endtask

// Divider drops req after the ack, then waits for ack low
task automatic finish_handshake();
	int n;
	n = 0;
	div_req = 1'b0;
	while (div_ack) begin
		step();
		n++;
		if (n > 20) fail_now("div_ack stayed high after div_req dropped");
	end
endtask

// Divider model, offers the quotient and follows the four-phase order
task automatic run_divider(input sboard_pkg::reg_addr_t q, input sboard_pkg::data_t v);
	int n;
	logic wrote;
	n = 0;
	wrote = 1'b0;
	check("div_ack", 64'(div_ack), 64'(0));
	div_req = 1'b1;
	quotient = v;
	while (!div_ack) begin
		step();
		if ((rf_dst.en && rf_dst.addr == q && rf_dst.data == v) ||
				(rf_src.en && rf_src.addr == q && rf_src.data == v))
			wrote = 1'b1;
		n++;
		if (n > 20) fail_now("div_ack did not rise after div_req");
	end
	// Ack rises on the same edge that registers the quotient write
	check("quotient_written", 64'(wrote), 64'(1));
	check("stall", 64'(stall), 64'(0));
	finish_handshake();
endtask

//--- bench/sboard_tb.sv
// Scoreboard bench top, runs the directed tests against sboard_top and reports the result
`timescale 1ns/1ps

module sboard_tb;

	localparam int CLK_PERIOD = 8;
	// Reset plus the directed tests, with a wide margin
	localparam int TEST_CYCLES = 130;
	localparam int TIMEOUT_NS = TEST_CYCLES * CLK_PERIOD * 4;

	logic sys_clk = 1'b0;
	logic resetl;
	sboard_pkg::issue_t issue;
	sboard_pkg::exec_t exec;
	sboard_pkg::data_t result;
	sboard_pkg::data_t srcdp;
	sboard_pkg::data_t imm_data;
	logic imm_wr;
	sboard_pkg::data_t quotient;
	logic div_req;
	logic stall;
	logic div_ack;
	sboard_pkg::rf_write_t rf_dst;
	sboard_pkg::rf_write_t rf_src;
	int unsigned seed_val;

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	sboard_top dut (
		.sys_clk(sys_clk), .resetl(resetl), .issue(issue), .exec(exec), .result(result),
		.srcdp(srcdp), .imm_data(imm_data), .imm_wr(imm_wr), .quotient(quotient),
		.div_req(div_req), .stall(stall), .div_ack(div_ack), .rf_dst(rf_dst), .rf_src(rf_src)
	);

	`include "tb_tasks.svh"

	// ALU write lands one cycle after pend, reader of its dst stalls meanwhile
	task automatic test_alu();
		sboard_pkg::reg_addr_t d;
		sboard_pkg::reg_addr_t u;
		sboard_pkg::data_t r;
		d = sboard_pkg::reg_addr_t'($urandom);
		u = d ^ 6'h15;
		r = $urandom;
		put_issue(d, d, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b1, 1'b0, 1'b0, 1'b0);
		put_issue(u, d, 1'b0, 1'b1, 1'b0);
		step();
		idle();
		result = r;
		check("alu_pend", 64'(dut.u_wb_arbiter.alu_pend), 64'(1));
		check_port("rf_dst", rf_dst, 1'b0, '0, '0);
		check("stall", 64'(stall), 64'(1));
		step();
		check_port("rf_dst", rf_dst, 1'b1, d, r);
		check("stall", 64'(stall), 64'(0));
		// Unrelated reader next to a pending ALU write
		put_issue(d, d, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b1, 1'b0, 1'b0, 1'b0);
		put_issue(u, u, 1'b1, 1'b1, 1'b0);
		step();
		idle();
		check("stall", 64'(stall), 64'(0));
		step();
		step();
	endtask

	// ALU outranks a move in the same cycle
	task automatic test_mov_priority();
		sboard_pkg::reg_addr_t a;
		sboard_pkg::reg_addr_t m;
		sboard_pkg::data_t r;
		sboard_pkg::data_t s;
		a = sboard_pkg::reg_addr_t'($urandom);
		m = a ^ 6'h2a;
		r = $urandom;
		s = $urandom;
		put_issue(a, a, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b1, 1'b0, 1'b0, 1'b0);
		put_issue(m, m, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b0, 1'b1, 1'b0, 1'b0);
		issue = '0;
		result = r;
		srcdp = s;
		step();
		idle();
		check_port("rf_dst", rf_dst, 1'b1, a, r);
		check_port("rf_src", rf_src, 1'b1, m, s);
		step();
		check_port("rf_dst", rf_dst, 1'b0, '0, '0);
	endtask

	task automatic test_imm();
		sboard_pkg::reg_addr_t i;
		sboard_pkg::data_t v;
		i = sboard_pkg::reg_addr_t'($urandom);
		v = $urandom;
		put_issue(i, i, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b0, 1'b0, 1'b1, 1'b0);
		issue = '0;
		step();
		idle();
		step();
		step();
		imm_wr = 1'b1;
		imm_data = v;
		step();
		imm_wr = 1'b0;
		check_port("rf_dst", rf_dst, 1'b1, i, v);
		check_port("rf_src", rf_src, 1'b0, '0, '0);
		step();
	endtask

	// Held instruction reads the divide dst, or is itself a second divide
	task automatic test_div_hazard(input logic second_div);
		sboard_pkg::reg_addr_t q;
		sboard_pkg::data_t v;
		q = sboard_pkg::reg_addr_t'($urandom);
		v = $urandom;
		put_issue(q, q, 1'b0, 1'b0, 1'b1);
		step();
		put_exec(1'b0, 1'b0, 1'b0, 1'b1);
		if (second_div)
			put_issue(q ^ 6'h01, q ^ 6'h01, 1'b0, 1'b0, 1'b1);
		else
			put_issue(q ^ 6'h01, q, 1'b0, 1'b1, 1'b0);
		step();
		idle();
		check("stall", 64'(stall), 64'(1));
		step();
		check("stall", 64'(stall), 64'(1));
		run_divider(q, v);
		check("stall", 64'(stall), 64'(0));
		step();
	endtask

	// Divide loses both ports to ALU and move, then writes on the next cycle
	task automatic test_div_backpressure();
		sboard_pkg::reg_addr_t q;
		sboard_pkg::reg_addr_t a;
		sboard_pkg::reg_addr_t m;
		sboard_pkg::data_t v;
		sboard_pkg::data_t r;
		sboard_pkg::data_t s;
		q = sboard_pkg::reg_addr_t'($urandom);
		a = q ^ 6'h11;
		m = q ^ 6'h22;
		v = $urandom;
		r = $urandom;
		s = $urandom;
		put_issue(q, q, 1'b0, 1'b0, 1'b1);
		step();
		put_exec(1'b0, 1'b0, 1'b0, 1'b1);
		put_issue(a, a, 1'b0, 1'b0, 1'b0);
		step();
		put_exec(1'b1, 1'b0, 1'b0, 1'b0);
		put_issue(m, m, 1'b0, 1'b0, 1'b0);
		div_req = 1'b1;
		quotient = v;
		step();
		put_exec(1'b0, 1'b1, 1'b0, 1'b0);
		issue = '0;
		result = r;
		srcdp = s;
		step();
		idle();
		check_port("rf_dst", rf_dst, 1'b1, a, r);
		check_port("rf_src", rf_src, 1'b1, m, s);
		check("div_ack", 64'(div_ack), 64'(0));
		step();
		check_port("rf_dst", rf_dst, 1'b1, q, v);
		check("div_ack", 64'(div_ack), 64'(1));
		finish_handshake();
		step();
	endtask

	initial begin
		#TIMEOUT_NS;
		$display("Run exceeded the time allowed for the tests");
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		seed_val = $urandom(32'h208a_4fab);
		resetl = 1'b0;
		idle();
		result = '0;
		srcdp = '0;
		imm_data = '0;
		quotient = '0;
		div_req = 1'b0;
		repeat (8) @(posedge sys_clk);
		#1;
		resetl = 1'b1;
		check("stall", 64'(stall), 64'(0));
		check("div_ack", 64'(div_ack), 64'(0));
		check("rf_dst.en", 64'(rf_dst.en), 64'(0));
		check("rf_src.en", 64'(rf_src.en), 64'(0));
		step();
		test_alu();
		test_mov_priority();
		test_imm();
		test_div_hazard(1'b0);
		test_div_hazard(1'b1);
		test_div_backpressure();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the scoreboard bench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module sboard_tb \
	-f sboard_top.f -o sboard_sim
out=$(./obj_dir/sboard_sim)
echo "$out"
echo "$out" | grep -q "Simulation passed"

//--- sboard_top.f
+incdir+bench
src/sboard_pkg.sv
src/operand_latch.sv
src/hazard_check.sv
src/divide_tracker.sv
src/wb_arbiter.sv
src/sboard_top.sv
bench/sboard_tb.sv

//--- src/divide_tracker.sv
// Tracks one in-flight divide from start to writeback and answers the divider's result handshake
`timescale 1ns/1ps

module divide_tracker (
	input logic sys_clk,
	input logic resetl,
	input sboard_pkg::operand_t cur,
	input sboard_pkg::exec_t exec,
	input logic div_req,
	input logic div_grant,
	output logic div_busy,
	output sboard_pkg::reg_addr_t div_addr,
	output logic div_wb_req,
	output logic div_ack
);

	logic start;
	logic req_seen;

	assign start = exec.exe & exec.div_start;

	// Quotient is offered and not yet queued for writeback
	assign req_seen = div_req & div_busy & ~div_wb_req & ~div_ack;

	// Destination of the divide, kept for hazard compare and writeback
	always_ff @(posedge sys_clk) begin
		if (start) begin
			div_addr <= cur.dst;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			div_busy <= 1'b0;
			div_wb_req <= 1'b0;
			div_ack <= 1'b0;
		end else begin
			// Busy from start until the quotient wins a write port
			if (start) begin
				div_busy <= 1'b1;
			end else if (div_grant) begin
				div_busy <= 1'b0;
			end

			// Writeback request waits out back-pressure from the arbiter
			if (div_grant) begin
				div_wb_req <= 1'b0;
			end else if (req_seen) begin
				div_wb_req <= 1'b1;
			end

			// Ack follows the write, released once the divider drops req
			if (div_grant) begin
				div_ack <= 1'b1;
			end else if (!div_req) begin
				div_ack <= 1'b0;
			end
		end
	end

	// Divider waits for ack low before offering the next quotient
	a_req_after_ack: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		div_ack |-> !$rose(div_req)
	);

	// Only one divide in flight, the hazard logic must hold a second one
	a_single_div: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		start |-> !div_busy
	);

endmodule

//--- src/hazard_check.sv
// Operand hazard compare, forms the core stall from pending ALU and divide destinations
`timescale 1ns/1ps

module hazard_check (
	input sboard_pkg::operand_t cur,
	input logic cur_is_div,
	input logic alu_pend,
	input logic div_busy,
	input sboard_pkg::reg_addr_t alu_addr,
	input sboard_pkg::reg_addr_t div_addr,
	output logic stall
);

	logic dst_alu_hit;
	logic src_alu_hit;
	logic dst_div_hit;
	logic src_div_hit;
	logic alu_wait;
	logic div_wait;
	logic div_unit_wait;

	// Operand compares, qualified by the read enables
	assign dst_alu_hit = cur.dst_rd & (cur.dst == alu_addr);
	assign src_alu_hit = cur.src_rd & (cur.src == alu_addr);
	assign dst_div_hit = cur.dst_rd & (cur.dst == div_addr);
	assign src_div_hit = cur.src_rd & (cur.src == div_addr);

	// ALU result still one cycle from the register file
	assign alu_wait = alu_pend & (dst_alu_hit | src_alu_hit);

	// Operand waits on the quotient
	assign div_wait = div_busy & (dst_div_hit | src_div_hit);

	// Second divide finds the divider occupied
	assign div_unit_wait = div_busy & cur_is_div;

	// Any one cause holds the core
	always_comb begin
		stall = alu_wait | div_wait | div_unit_wait;
	end

endmodule

//--- src/operand_latch.sv
// Issue stage register, holds the operand addresses of the current instruction for the hazard logic
`timescale 1ns/1ps

module operand_latch (
	input logic sys_clk,
	input logic resetl,
	input sboard_pkg::issue_t issue,
	input logic stall,
	output sboard_pkg::operand_t cur,
	output logic cur_is_div
);

	logic take;

	// New instruction accepted only when the core is not held
	assign take = issue.valid & ~stall;

	always_ff @(posedge sys_clk) begin
		// Addresses only matter while a read enable is set
		if (take) begin
			cur.dst <= issue.dst;
			cur.src <= issue.src;
		end

		if (!resetl) begin
			cur.dst_rd <= 1'b0;
			cur.src_rd <= 1'b0;
			cur_is_div <= 1'b0;
		end else if (!stall) begin
			// Empty issue slot leaves no read enable behind
			cur.dst_rd <= issue.valid & issue.dst_rd;
			cur.src_rd <= issue.valid & issue.src_rd;
			cur_is_div <= issue.valid & issue.is_div;
		end
		// Stalled, everything holds
	end

endmodule

//--- src/sboard_pkg.sv
// Shared widths, types and port structs of the register-file scoreboard, used by scoped name
package sboard_pkg;

	// Register file geometry, 64 registers of 32 bits
	localparam int REG_ADDR_W = 6;
	localparam int DATA_W = 32;

	// Number of writeback sources sharing the two write ports
	localparam int WB_SRC_N = 4;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Instruction entering issue
	typedef struct packed {
		logic valid;
		reg_addr_t dst;
		reg_addr_t src;
		logic dst_rd;
		logic src_rd;
		logic is_div;
	} issue_t;

	// Execute controls for the instruction now held in the operand latch
	typedef struct packed {
		logic exe;
		logic alu_wr;
		logic mov_wr;
		logic imm_ld;
		logic div_start;
	} exec_t;

	// Writeback sources, highest priority first
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MOV = 2'd1,
		WB_IMM = 2'd2,
		WB_DIV = 2'd3
	} wb_src_e;

	// One register-file write port
	typedef struct packed {
		logic en;
		reg_addr_t addr;
		data_t data;
	} rf_write_t;

	// Operands of the latched instruction
	typedef struct packed {
		reg_addr_t dst;
		reg_addr_t src;
		logic dst_rd;
		logic src_rd;
	} operand_t;

endpackage

//--- src/sboard_top.sv
// Scoreboard top level, operand latch feeding hazard check, divide tracker and writeback arbiter
`timescale 1ns/1ps

module sboard_top (
	input logic sys_clk,
	input logic resetl,
	input sboard_pkg::issue_t issue,
	input sboard_pkg::exec_t exec,
	input sboard_pkg::data_t result,
	input sboard_pkg::data_t srcdp,
	input sboard_pkg::data_t imm_data,
	input logic imm_wr,
	input sboard_pkg::data_t quotient,
	input logic div_req,
	output logic stall,
	output logic div_ack,
	output sboard_pkg::rf_write_t rf_dst,
	output sboard_pkg::rf_write_t rf_src
);

	sboard_pkg::operand_t cur;
	logic cur_is_div;
	logic alu_pend;
	sboard_pkg::reg_addr_t alu_addr;
	logic div_busy;
	sboard_pkg::reg_addr_t div_addr;
	logic div_wb_req;
	logic div_grant;

	// Input side
	operand_latch u_operand_latch (
		.sys_clk(sys_clk), .resetl(resetl), .issue(issue), .stall(stall),
		.cur(cur), .cur_is_div(cur_is_div)
	);

	// Hazard compare and stall
	hazard_check u_hazard_check (
		.cur(cur), .cur_is_div(cur_is_div), .alu_pend(alu_pend), .div_busy(div_busy),
		.alu_addr(alu_addr), .div_addr(div_addr), .stall(stall)
	);

	// In-flight divide and divider handshake
	divide_tracker u_divide_tracker (
		.sys_clk(sys_clk), .resetl(resetl), .cur(cur), .exec(exec), .div_req(div_req),
		.div_grant(div_grant), .div_busy(div_busy), .div_addr(div_addr),
		.div_wb_req(div_wb_req), .div_ack(div_ack)
	);

	// Output side, two register-file write ports
	wb_arbiter u_wb_arbiter (
		.sys_clk(sys_clk), .resetl(resetl), .cur(cur), .exec(exec), .imm_wr(imm_wr),
		.div_wb_req(div_wb_req), .div_addr(div_addr), .result(result), .srcdp(srcdp),
		.imm_data(imm_data), .quotient(quotient), .alu_pend(alu_pend),
		.alu_addr(alu_addr), .div_grant(div_grant), .rf_dst(rf_dst), .rf_src(rf_src)
	);

endmodule

//--- src/wb_arbiter.sv
// Writeback arbiter, ranks ALU, move, immediate and divide onto the two register-file write ports
`timescale 1ns/1ps

module wb_arbiter (
	input logic sys_clk,
	input logic resetl,
	input sboard_pkg::operand_t cur,
	input sboard_pkg::exec_t exec,
	input logic imm_wr,
	input logic div_wb_req,
	input sboard_pkg::reg_addr_t div_addr,
	input sboard_pkg::data_t result,
	input sboard_pkg::data_t srcdp,
	input sboard_pkg::data_t imm_data,
	input sboard_pkg::data_t quotient,
	output logic alu_pend,
	output sboard_pkg::reg_addr_t alu_addr,
	output logic div_grant,
	output sboard_pkg::rf_write_t rf_dst,
	output sboard_pkg::rf_write_t rf_src
);

	sboard_pkg::reg_addr_t imm_addr;
	logic [sboard_pkg::WB_SRC_N-1:0] req;
	sboard_pkg::reg_addr_t req_addr [sboard_pkg::WB_SRC_N];
	sboard_pkg::data_t req_data [sboard_pkg::WB_SRC_N];
	logic dst_hit;
	logic src_hit;
	sboard_pkg::wb_src_e dst_sel;
	sboard_pkg::wb_src_e src_sel;

	// ALU result lands one cycle after exe
	always_ff @(posedge sys_clk) begin
		if (exec.exe && exec.alu_wr) begin
			alu_addr <= cur.dst;
		end
		if (!resetl) begin
			alu_pend <= 1'b0;
		end else begin
			alu_pend <= exec.exe & exec.alu_wr;
		end
	end

	// Immediate destination, written later by imm_wr
	always_ff @(posedge sys_clk) begin
		if (exec.exe && exec.imm_ld) begin
			imm_addr <= cur.dst;
		end
	end

	// Request vector and per-source address and data, indexed by priority
	always_comb begin
		req[sboard_pkg::WB_ALU] = alu_pend;
		req[sboard_pkg::WB_MOV] = exec.exe & exec.mov_wr;
		req[sboard_pkg::WB_IMM] = imm_wr;
		req[sboard_pkg::WB_DIV] = div_wb_req;

		req_addr[sboard_pkg::WB_ALU] = alu_addr;
		req_addr[sboard_pkg::WB_MOV] = cur.dst;
		req_addr[sboard_pkg::WB_IMM] = imm_addr;
		req_addr[sboard_pkg::WB_DIV] = div_addr;

		req_data[sboard_pkg::WB_ALU] = result;
		req_data[sboard_pkg::WB_MOV] = srcdp;
		req_data[sboard_pkg::WB_IMM] = imm_data;
		req_data[sboard_pkg::WB_DIV] = quotient;
	end

	// First active source takes the dst port, second takes the src port
	always_comb begin
		dst_hit = 1'b0;
		src_hit = 1'b0;
		dst_sel = sboard_pkg::WB_ALU;
		src_sel = sboard_pkg::WB_ALU;
		for (int i = 0; i < sboard_pkg::WB_SRC_N; i++) begin
			if (req[i]) begin
				if (!dst_hit) begin
					dst_hit = 1'b1;
					dst_sel = sboard_pkg::wb_src_e'(i);
				end else if (!src_hit) begin
					src_hit = 1'b1;
					src_sel = sboard_pkg::wb_src_e'(i);
				end
			end
		end
	end

	// Divide written this cycle on either port, a third requester waits
	assign div_grant = (dst_hit && dst_sel == sboard_pkg::WB_DIV) ||
		(src_hit && src_sel == sboard_pkg::WB_DIV);

	// Write ports registered, one cycle per winning request
	always_ff @(posedge sys_clk) begin
		rf_dst.addr <= req_addr[dst_sel];
		rf_dst.data <= req_data[dst_sel];
		rf_src.addr <= req_addr[src_sel];
		rf_src.data <= req_data[src_sel];
		if (!resetl) begin
			rf_dst.en <= 1'b0;
			rf_src.en <= 1'b0;
		end else begin
			rf_dst.en <= dst_hit;
			rf_src.en <= src_hit;
		end
	end

	// Only the divide may be back-pressured, the other three always fit
	a_two_fast: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		$countones(req[sboard_pkg::WB_IMM:sboard_pkg::WB_ALU]) <= 2
	);

endmodule
